// ==== dv/fpga_image_loader_tb.sv ====
`include "fpga_load_defines.svh"

module fpga_image_loader_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic                        sys_clk;
	logic                        glbl_rst_n;
	logic                        load_en;
	logic                        init_ok;
	fpga_load_pkg::stream_beat_t flash_rsp;
	fpga_load_pkg::flash_req_t   flash_req;
	fpga_load_pkg::target_wr_t   target_wr;
	logic                        busy;
	logic                        load_done;
	logic                        load_error;
	fpga_load_pkg::crc_t         image_crc;

	int          err_cnt = 0;
	int          check_cnt = 0;
	int          wr_cnt = 0;
	int          flag_cnt = 0;
	int          result_cycles;
	logic [31:0] lfsr_state = 32'h55ca_6f9c;
	logic [31:0] trailer_word;
	logic [7:0]  mem_model [int];
	logic [7:0]  payload_q [$];
	logic [7:0]  image_q [$];

	fpga_image_loader UUT (
		.sys_clk    (sys_clk),
		.glbl_rst_n (glbl_rst_n),
		.load_en    (load_en),
		.init_ok    (init_ok),
		.flash_req  (flash_req),
		.flash_rsp  (flash_rsp),
		.target_wr  (target_wr),
		.busy       (busy),
		.load_done  (load_done),
		.load_error (load_error),
		.image_crc  (image_crc)
	);

	initial
	begin
		sys_clk = 1'b0;
	end

	always #4 sys_clk = ~sys_clk;

	// Image memory model sampled mid cycle
	always @(negedge sys_clk)
	begin
		if (target_wr.wren)
		begin
			mem_model[int'(target_wr.addr)] = target_wr.wdata;
			wr_cnt++;
			if (target_wr.addr == `TARGET_FLAG_ADDR)
			begin
				flag_cnt++;
			end
		end
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
		begin
			n = n ^ 32'h8020_0003;
		end
		return n;
	endfunction

	// One LFSR step per payload bit
	function automatic logic [7:0] random_byte();
		logic [7:0] b;
		int         i;
		for (i = 0; i < 8; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			b[i] = lfsr_state[0];
		end
		return b;
	endfunction

	// Reflected CRC-32 over the payload bit by bit
	function automatic logic [31:0] ref_crc32();
		logic [31:0] crc;
		logic        fb;
		int          n;
		int          k;
		crc = 32'hffff_ffff;
		for (n = 0; n < payload_q.size(); n++)
		begin
			for (k = 0; k < 8; k++)
			begin
				fb = crc[0] ^ payload_q[n][k];
				crc = crc >> 1;
				if (fb)
				begin
					crc = crc ^ 32'hedb8_8320;
				end
			end
		end
		return ~crc;
	endfunction

	task automatic tick();
		@(posedge sys_clk);
		#1;
	endtask

	task automatic make_payload(input int len);
		int i;
		payload_q.delete();
		for (i = 0; i < len; i++)
		begin
			payload_q.push_back(random_byte());
		end
	endtask

	// Trailer goes out LSB first
	task automatic build_image(input logic [31:0] flip_mask);
		image_q = payload_q;
		trailer_word = ref_crc32() ^ flip_mask;
		image_q.push_back(trailer_word[7:0]);
		image_q.push_back(trailer_word[15:8]);
		image_q.push_back(trailer_word[23:16]);
		image_q.push_back(trailer_word[31:24]);
	endtask

	task automatic clear_mem();
		mem_model.delete();
		wr_cnt = 0;
		flag_cnt = 0;
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		check_cnt++;
		if (actual !== expected)
		begin
			err_cnt++;
			$display("ERR %0d ns %s: got %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	task automatic report_failure(input string what);
		err_cnt++;
		$display("%0d ns: %s", $time, what);
	endtask

	task automatic finish_test(input string name, input int start_err);
		$display("test %s: %s", name, (err_cnt == start_err) ? "pass" : "fail");
	endtask

	////////////////////
	// Load sequence
	////////////////////

	task automatic start_load();
		load_en = 1'b1;
		tick();
		load_en = 1'b0;
	endtask

	task automatic stream_image();
		int i;
		for (i = 0; i < image_q.size(); i++)
		begin
			flash_rsp.valid = 1'b1;
			flash_rsp.last  = (i == image_q.size() - 1);
			flash_rsp.data  = image_q[i];
			// Write goes out in the same cycle as its beat
			@(negedge sys_clk);
			check_value("target_wr.wren", target_wr.wren, 1);
			check_value("target_wr.addr", target_wr.addr, int'(`TARGET_IMAGE_BASE) + i);
			check_value("target_wr.wdata", target_wr.wdata, image_q[i]);
			tick();
		end
		flash_rsp = '0;
	endtask

	// Counts edges after the one that took the last beat
	task automatic wait_result();
		result_cycles = 0;
		while (!load_done && !load_error && result_cycles < 40)
		begin
			tick();
			result_cycles++;
		end
		if (!load_done && !load_error)
		begin
			report_failure("no done or error pulse within 40 cycles of the last beat");
		end
	endtask

	task automatic check_load(input logic expect_done);
		int i;
		int addr;
		check_value("result delay", result_cycles, 2);
		check_value("load_done", load_done, expect_done);
		check_value("load_error", load_error, !expect_done);
		check_value("busy", busy, 0);
		check_value("image_crc", image_crc, trailer_word);
		tick();
		check_value("load_done", load_done, 0);
		check_value("load_error", load_error, 0);
		check_value("image_crc", image_crc, trailer_word);
		check_value("write count", wr_cnt, image_q.size());
		for (i = 0; i < image_q.size(); i++)
		begin
			addr = int'(`TARGET_IMAGE_BASE) + i;
			if (!mem_model.exists(addr))
			begin
				report_failure($sformatf("image byte %0d was never written", i));
			end
			else
			begin
				check_value($sformatf("image byte %0d", i), mem_model[addr], image_q[i]);
			end
		end
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic test_reset_idle();
		int start;
		int i;
		start = err_cnt;
		check_value("busy", busy, 0);
		check_value("load_done", load_done, 0);
		check_value("load_error", load_error, 0);
		check_value("flash_req.rden", flash_req.rden, 0);
		check_value("target_wr.wren", target_wr.wren, 0);
		clear_mem();
		for (i = 0; i < 3; i++)
		begin
			flash_rsp.valid = 1'b1;
			flash_rsp.last  = (i == 2);
			flash_rsp.data  = 8'h5a + i;
			tick();
		end
		flash_rsp = '0;
		tick();
		check_value("idle write count", wr_cnt, 0);
		check_value("busy", busy, 0);
		finish_test("reset and idle stream", start);
	endtask

	task automatic test_flash_request();
		int start;
		int c;
		int rden_cnt;
		start = err_cnt;
		rden_cnt = 0;
		load_en = 1'b1;
		tick();
		load_en = 1'b0;
		for (c = 0; c < 6; c++)
		begin
			if (flash_req.rden)
			begin
				rden_cnt++;
				check_value("flash_req.addr", flash_req.addr, `FLASH_IMAGE_ADDR);
				check_value("flash_req.length", flash_req.length, `FLASH_IMAGE_LEN);
			end
			else
			begin
				check_value("flash_req", flash_req, 0);
			end
			check_value("busy", busy, 1);
			// Second request while busy
			load_en = (c == 2);
			tick();
		end
		load_en = 1'b0;
		check_value("rden cycles", rden_cnt, 1);
		make_payload(4);
		build_image(32'h0);
		clear_mem();
		stream_image();
		wait_result();
		check_load(1'b1);
		finish_test("flash request", start);
	endtask

	task automatic test_good_image();
		int start;
		start = err_cnt;
		make_payload(16);
		build_image(32'h0);
		clear_mem();
		start_load();
		stream_image();
		wait_result();
		check_load(1'b1);
		finish_test("good image", start);
	endtask

	// Reuses the payload of the good image
	task automatic test_bad_trailer();
		int start;
		start = err_cnt;
		build_image(32'h0000_0400);
		clear_mem();
		start_load();
		stream_image();
		wait_result();
		check_load(1'b0);
		finish_test("corrupted trailer", start);
	endtask

	task automatic test_flag_write();
		int start;
		start = err_cnt;
		clear_mem();
		init_ok = 1'b1;
		tick();
		init_ok = 1'b0;
		check_value("target_wr.wren", target_wr.wren, 1);
		check_value("target_wr.addr", target_wr.addr, `TARGET_FLAG_ADDR);
		check_value("target_wr.wdata", target_wr.wdata, `TARGET_FLAG_VALUE);
		tick();
		check_value("target_wr", target_wr, 0);
		tick();
		check_value("flag writes", flag_cnt, 1);
		if (!mem_model.exists(int'(`TARGET_FLAG_ADDR)))
		begin
			report_failure("ready flag byte was never written");
		end
		else
		begin
			check_value("flag byte", mem_model[int'(`TARGET_FLAG_ADDR)], `TARGET_FLAG_VALUE);
		end
		// init_ok during a load
		clear_mem();
		build_image(32'h0);
		start_load();
		init_ok = 1'b1;
		tick();
		init_ok = 1'b0;
		stream_image();
		wait_result();
		check_load(1'b1);
		check_value("flag writes in load", flag_cnt, 0);
		finish_test("flag write", start);
	endtask

	task automatic test_back_to_back();
		int start;
		start = err_cnt;
		make_payload(16);
		build_image(32'h0);
		clear_mem();
		start_load();
		stream_image();
		wait_result();
		check_load(1'b1);
		make_payload(40);
		build_image(32'h0);
		clear_mem();
		start_load();
		stream_image();
		wait_result();
		check_load(1'b1);
		finish_test("back to back loads", start);
	endtask

	initial
	begin
		glbl_rst_n = 1'b0;
		load_en    = 1'b0;
		init_ok    = 1'b0;
		flash_rsp  = '0;
		repeat (5) @(posedge sys_clk);
		#1;
		glbl_rst_n = 1'b1;

		test_reset_idle();
		test_flash_request();
		test_good_image();
		test_bad_trailer();
		test_flag_write();
		test_back_to_back();

		$display("checks %0d, errors %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
		begin
			$display("Result: PASSED");
		end
		else
		begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/fpga_load_pkg.sv
verilog/load_sequencer.sv
verilog/target_write_port.sv
verilog/crc32_byte_checker.sv
verilog/fpga_image_loader.sv
dv/fpga_image_loader_tb.sv

// ==== verilog/crc32_byte_checker.sv ====
module crc32_byte_checker (
	input  logic                        sys_clk,
	input  logic                        glbl_rst_n,

	input  logic                        busy,
	input  fpga_load_pkg::stream_beat_t flash_rsp,

	// Check result, one cycle after the last beat
	output logic                        check_valid,
	output logic                        crc_match,

	// Received trailer word
	output fpga_load_pkg::crc_t         image_crc
);

	// Reflected form of 04C11DB7
	localparam fpga_load_pkg::crc_t CRC_POLY_REFL = 32'hedb88320;

	fpga_load_pkg::crc_t crc_q;
	fpga_load_pkg::crc_t crc_next;
	fpga_load_pkg::crc_t line;
	fpga_load_pkg::crc_t trailer;
	logic [2:0]          fill;
	logic                line_full;
	logic                accept;
	logic                busy_q;

	// One byte into the running CRC, LSB first
	function automatic fpga_load_pkg::crc_t crc32_byte(input fpga_load_pkg::crc_t crc_in,
		input fpga_load_pkg::byte_t data);
		fpga_load_pkg::crc_t c;
		int                  i;
		c = crc_in ^ {24'd0, data};
		for (i = 0; i < 8; i++)
		begin
			c = c[0] ? ((c >> 1) ^ CRC_POLY_REFL) : (c >> 1);
		end
		return c;
	endfunction

	assign accept    = busy & flash_rsp.valid;
	assign line_full = (fill == 3'd4);

	// Byte leaving the line is payload for sure
	assign crc_next = line_full ? crc32_byte(crc_q, line[7:0]) : crc_q;

	// Newest byte on top, so the first trailer byte ends up as LSB
	assign trailer = {flash_rsp.data, line[31:8]};

	////////////////////
	// Four byte delay line
	////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!busy)
		begin
			line <= '0;
		end
		else if (accept)
		begin
			line <= trailer;
		end
	end

	////////////////////
	// CRC and compare
	////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			crc_q       <= '1;
			fill        <= 3'd0;
			check_valid <= 1'b0;
			crc_match   <= 1'b0;
			image_crc   <= '0;
			busy_q      <= 1'b0;
		end
		else
		begin
			busy_q      <= busy;
			check_valid <= 1'b0;

			// New load clears the old trailer
			if (busy && !busy_q)
			begin
				image_crc <= '0;
			end

			if (!busy)
			begin
				crc_q     <= '1;
				fill      <= 3'd0;
				crc_match <= 1'b0;
			end
			else if (accept)
			begin
				crc_q <= crc_next;
				if (!line_full)
				begin
					fill <= fill + 3'd1;
				end
				if (flash_rsp.last)
				begin
					check_valid <= 1'b1;
					crc_match   <= (~crc_next == trailer);
					image_crc   <= trailer;
				end
			end
		end
	end

endmodule

// ==== verilog/fpga_image_loader.sv ====
module fpga_image_loader (
	input  logic                        sys_clk,
	input  logic                        glbl_rst_n,

	// Control
	input  logic                        load_en,
	input  logic                        init_ok,

	// Flash controller
	output fpga_load_pkg::flash_req_t   flash_req,
	input  fpga_load_pkg::stream_beat_t flash_rsp,

	// Auxiliary image memory
	output fpga_load_pkg::target_wr_t   target_wr,

	// Status
	output logic                        busy,
	output logic                        load_done,
	output logic                        load_error,
	output fpga_load_pkg::crc_t         image_crc
);

	logic flag_wr;
	logic check_valid;
	logic crc_match;

	////////////////////
	// Control
	////////////////////

	load_sequencer u_load_sequencer (
		.sys_clk     (sys_clk),
		.glbl_rst_n  (glbl_rst_n),
		.load_en     (load_en),
		.init_ok     (init_ok),
		.check_valid (check_valid),
		.crc_match   (crc_match),
		.busy        (busy),
		.flag_wr     (flag_wr),
		.load_done   (load_done),
		.load_error  (load_error),
		.flash_req   (flash_req)
	);

	////////////////////
	// Data path
	////////////////////

	target_write_port u_target_write_port (
		.sys_clk    (sys_clk),
		.glbl_rst_n (glbl_rst_n),
		.busy       (busy),
		.flag_wr    (flag_wr),
		.flash_rsp  (flash_rsp),
		.target_wr  (target_wr)
	);

	crc32_byte_checker u_crc32_byte_checker (
		.sys_clk     (sys_clk),
		.glbl_rst_n  (glbl_rst_n),
		.busy        (busy),
		.flash_rsp   (flash_rsp),
		.check_valid (check_valid),
		.crc_match   (crc_match),
		.image_crc   (image_crc)
	);

endmodule

// ==== verilog/fpga_load_defines.svh ====
`ifndef FPGA_LOAD_DEFINES_SVH
`define FPGA_LOAD_DEFINES_SVH

////////////////////
// Flash side of the load
////////////////////

// Byte address of the auxiliary image in serial flash
`define FLASH_IMAGE_ADDR 25'h2e400

// Bytes requested per load, trailer included
`define FLASH_IMAGE_LEN 24'h20000

////////////////////
// Auxiliary FPGA image memory
////////////////////

// First image byte lands here
`define TARGET_IMAGE_BASE 23'h400000

// Ready flag location and its value
`define TARGET_FLAG_ADDR 23'h000000
`define TARGET_FLAG_VALUE 8'h80

`endif

// ==== verilog/fpga_load_pkg.sv ====
package fpga_load_pkg;

	////////////////////
	// Widths with a meaning
	////////////////////

	// One stream or memory data byte
	typedef logic [7:0] byte_t;
	// Flash byte address
	typedef logic [24:0] flash_addr_t;
	// Flash read length in bytes
	typedef logic [23:0] flash_len_t;
	// Auxiliary image memory address
	typedef logic [22:0] target_addr_t;
	// CRC-32 value, also the trailer word
	typedef logic [31:0] crc_t;

	// Loader sequence
	typedef enum logic [1:0] {
		LOAD_IDLE   = 2'd0,
		LOAD_STREAM = 2'd1,
		LOAD_CHECK  = 2'd2
	} load_state_t;

	////////////////////
	// Bundles
	////////////////////

	// Read request to the flash controller
	typedef struct packed {
		logic        rden;
		flash_addr_t addr;
		flash_len_t  length;
	} flash_req_t;

	// Byte returned by the flash controller, no back-pressure
	typedef struct packed {
		logic  valid;
		logic  last;
		byte_t data;
	} stream_beat_t;

	// Write beat into the auxiliary image memory
	typedef struct packed {
		logic         wren;
		target_addr_t addr;
		byte_t        wdata;
	} target_wr_t;

endpackage

// ==== verilog/load_sequencer.sv ====
`include "fpga_load_defines.svh"

module load_sequencer (
	input  logic                    sys_clk,
	input  logic                    glbl_rst_n,

	// Control pulses
	input  logic                    load_en,
	input  logic                    init_ok,

	// Result of the CRC check
	input  logic                    check_valid,
	input  logic                    crc_match,

	// Status
	output logic                    busy,
	output logic                    flag_wr,
	output logic                    load_done,
	output logic                    load_error,

	// Flash read request
	output fpga_load_pkg::flash_req_t flash_req
);

	fpga_load_pkg::load_state_t state;

	////////////////////
	// Sequencer FSM
	////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state      <= fpga_load_pkg::LOAD_IDLE;
			busy       <= 1'b0;
			flag_wr    <= 1'b0;
			load_done  <= 1'b0;
			load_error <= 1'b0;
			flash_req  <= '0;
		end
		else
		begin
			// All strobes last a single cycle
			flash_req  <= '0;
			flag_wr    <= 1'b0;
			load_done  <= 1'b0;
			load_error <= 1'b0;

			case (state)
				fpga_load_pkg::LOAD_IDLE:
				begin
					if (load_en)
					begin
						state            <= fpga_load_pkg::LOAD_STREAM;
						busy             <= 1'b1;
						flash_req.rden   <= 1'b1;
						flash_req.addr   <= `FLASH_IMAGE_ADDR;
						flash_req.length <= `FLASH_IMAGE_LEN;
					end
					else if (init_ok)
					begin
						// Ready flag only goes out between loads
						flag_wr <= 1'b1;
					end
				end

				fpga_load_pkg::LOAD_STREAM:
				begin
					// Checker reports one edge after the last beat
					if (check_valid)
					begin
						state <= fpga_load_pkg::LOAD_CHECK;
					end
				end

				fpga_load_pkg::LOAD_CHECK:
				begin
					state <= fpga_load_pkg::LOAD_IDLE;
					busy  <= 1'b0;
					if (crc_match)
					begin
						load_done <= 1'b1;
					end
					else
					begin
						load_error <= 1'b1;
					end
				end

				default:
				begin
					state <= fpga_load_pkg::LOAD_IDLE;
					busy  <= 1'b0;
				end
			endcase
		end
	end

endmodule

// ==== verilog/target_write_port.sv ====
`include "fpga_load_defines.svh"

module target_write_port (
	input  logic                        sys_clk,
	input  logic                        glbl_rst_n,

	// From the sequencer
	input  logic                        busy,
	input  logic                        flag_wr,

	// Byte stream from flash
	input  fpga_load_pkg::stream_beat_t flash_rsp,

	// Image memory write
	output fpga_load_pkg::target_wr_t   target_wr
);

	fpga_load_pkg::target_addr_t addr_cnt;
	logic                        accept;

	// Stream is only taken while a load runs
	assign accept = busy & flash_rsp.valid;

	////////////////////
	// Image address counter
	////////////////////

	// Back at the image base whenever no load is running
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			addr_cnt <= `TARGET_IMAGE_BASE;
		end
		else if (!busy)
		begin
			addr_cnt <= `TARGET_IMAGE_BASE;
		end
		else if (accept)
		begin
			addr_cnt <= addr_cnt + 23'd1;
		end
	end

	////////////////////
	// Write beat
	////////////////////

	always_comb
	begin
		// Nothing written means address and data stay zero
		target_wr = '0;
		if (flag_wr)
		begin
			target_wr.wren  = 1'b1;
			target_wr.addr  = `TARGET_FLAG_ADDR;
			target_wr.wdata = `TARGET_FLAG_VALUE;
		end
		else if (accept)
		begin
			// Trailer bytes get written as well
			target_wr.wren  = 1'b1;
			target_wr.addr  = addr_cnt;
			target_wr.wdata = flash_rsp.data;
		end
	end

endmodule
